//--- rtl/rsa_pkg.sv
package rsa_pkg;

    // ============================================================
    // Modular arithmetic core
    // ============================================================

    // Operand width unless the top level overrides it
    localparam int default_key_bits = 256;

    // Exponentiation controller
    typedef enum logic [2:0] {
        core_idle,
        core_prep,
        core_square,
        core_multiply,
        core_done
    } core_state_e;

    // Shared by the Montgomery multiplier and the domain conversion
    typedef enum logic [1:0] {
        mont_idle,
        mont_run,
        mont_done
    } mont_state_e;

endpackage

//--- rtl/avm_pkg.sv
package avm_pkg;

    // ============================================================
    // UART register block
    // ============================================================

    localparam int addr_bits = 5;

    localparam logic [addr_bits-1:0] rx_base     = 5'd0;
    localparam logic [addr_bits-1:0] tx_base     = 5'd4;
    localparam logic [addr_bits-1:0] status_base = 5'd8;

    localparam int tx_ok_bit = 6;
    localparam int rx_ok_bit = 7;

    // ============================================================
    // Bus controller
    // ============================================================

    typedef enum logic [2:0] {
        poll_rx,
        read_n,
        read_d,
        read_c,
        compute,
        poll_tx,
        send
    } bus_state_e;

    // Operand being loaded from the receive register
    typedef enum logic [1:0] {
        field_n,
        field_d,
        field_c
    } field_e;

endpackage

//--- rtl/rsa_modprod.sv
module rsa_modprod #(
    parameter int key_bits = rsa_pkg::default_key_bits
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [key_bits-1:0] a,
    input  logic [key_bits-1:0] n,
    output logic [key_bits-1:0] result,
    output logic                finished
);
    import rsa_pkg::*;

    localparam int cnt_bits = $clog2(key_bits);

    mont_state_e         state;
    logic [cnt_bits-1:0] cnt;
    logic [key_bits-1:0] r;
    logic [key_bits:0]   r_dbl;
    logic [key_bits:0]   r_red;

    // Double and fold back below n
    assign r_dbl = {r, 1'b0};
    assign r_red = (r_dbl >= {1'b0, n}) ? r_dbl - {1'b0, n} : r_dbl;

    assign result   = r;
    assign finished = (state == mont_done);

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state <= mont_idle;
            cnt   <= '0;
        end else begin
            case (state)
                mont_idle: begin
                    if (start) begin
                        state <= mont_run;
                        cnt   <= '0;
                    end
                end
                mont_run: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cnt_bits'(key_bits - 1)) begin
                        state <= mont_done;
                    end
                end
                default: state <= mont_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == mont_idle && start) begin
            // Base may sit one modulus above n
            r <= (a >= n) ? a - n : a;
        end else if (state == mont_run) begin
            r <= r_red[key_bits-1:0];
        end
    end

    a_start_when_free: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> state != mont_run);

endmodule

//--- rtl/rsa_mont.sv
module rsa_mont #(
    parameter int key_bits = rsa_pkg::default_key_bits
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [key_bits-1:0] a,
    input  logic [key_bits-1:0] b,
    input  logic [key_bits-1:0] n,
    output logic [key_bits-1:0] result,
    output logic                finished
);
    import rsa_pkg::*;

    localparam int cnt_bits = $clog2(key_bits);

    mont_state_e         state;
    logic [cnt_bits-1:0] cnt;
    logic [key_bits-1:0] a_sh;
    logic [key_bits:0]   s;
    logic [key_bits+1:0] s_add;
    logic [key_bits+1:0] s_odd;
    logic [key_bits:0]   s_half;
    logic                last;

    // One step of the radix-2 recurrence, s stays below 2n
    assign s_add  = {1'b0, s} + (a_sh[0] ? {2'b00, b} : '0);
    assign s_odd  = s_add[0] ? s_add + {2'b00, n} : s_add;
    assign s_half = s_odd[key_bits+1:1];
    assign last   = (cnt == cnt_bits'(key_bits - 1));

    assign result   = s[key_bits-1:0];
    assign finished = (state == mont_done);

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state <= mont_idle;
            cnt   <= '0;
        end else begin
            case (state)
                mont_idle: begin
                    if (start) begin
                        state <= mont_run;
                        cnt   <= '0;
                    end
                end
                mont_run: begin
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state <= mont_done;
                    end
                end
                default: state <= mont_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == mont_idle && start) begin
            s    <= '0;
            a_sh <= a;
        end else if (state == mont_run) begin
            a_sh <= a_sh >> 1;
            // Final subtraction folded into the last step
            if (last && s_half >= {1'b0, n}) begin
                s <= s_half - {1'b0, n};
            end else begin
                s <= s_half;
            end
        end
    end

    a_result_reduced: assert property (@(posedge avm_clk) disable iff (avm_rst)
        finished |-> result < n);

endmodule

//--- rtl/rsa_core.sv
module rsa_core #(
    parameter int key_bits = rsa_pkg::default_key_bits
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [key_bits-1:0] a,
    input  logic [key_bits-1:0] d,
    input  logic [key_bits-1:0] n,
    output logic [key_bits-1:0] result,
    output logic                finished
);
    import rsa_pkg::*;

    localparam int bit_cnt_bits = $clog2(key_bits);

    core_state_e             state;
    logic [bit_cnt_bits-1:0] bit_cnt;
    logic [key_bits-1:0]     acc;
    logic [key_bits-1:0]     pw;
    logic [key_bits-1:0]     d_sh;
    logic [key_bits-1:0]     mp_result;
    logic [key_bits-1:0]     mm_result;
    logic [key_bits-1:0]     mm_a;
    logic                    mp_start;
    logic                    mp_finished;
    logic                    mm_start;
    logic                    mm_finished;
    logic                    last_bit;

    // ============================================================
    // Arithmetic units
    // ============================================================

    rsa_modprod #(
        .key_bits (key_bits)
    ) u_modprod (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (mp_start),
        .a        (a),
        .n        (n),
        .result   (mp_result),
        .finished (mp_finished)
    );

    // One multiplier, shared between square and multiply
    assign mm_a = (state == core_multiply) ? acc : pw;

    rsa_mont #(
        .key_bits (key_bits)
    ) u_mont (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (mm_start),
        .a        (mm_a),
        .b        (pw),
        .n        (n),
        .result   (mm_result),
        .finished (mm_finished)
    );

    assign last_bit = (bit_cnt == bit_cnt_bits'(key_bits - 1));
    assign result   = acc;
    assign finished = (state == core_done);

    // ============================================================
    // Square-and-multiply, exponent LSB first
    // ============================================================

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= core_idle;
            bit_cnt  <= '0;
            mp_start <= 1'b0;
            mm_start <= 1'b0;
        end else begin
            mp_start <= 1'b0;
            mm_start <= 1'b0;
            case (state)
                core_idle: begin
                    if (start) begin
                        state    <= core_prep;
                        bit_cnt  <= '0;
                        mp_start <= 1'b1;
                    end
                end
                core_prep: begin
                    if (mp_finished) begin
                        mm_start <= 1'b1;
                        state    <= d_sh[0] ? core_multiply : core_square;
                    end
                end
                core_multiply: begin
                    if (mm_finished) begin
                        mm_start <= 1'b1;
                        state    <= core_square;
                    end
                end
                core_square: begin
                    if (mm_finished) begin
                        if (last_bit) begin
                            state <= core_done;
                        end else begin
                            mm_start <= 1'b1;
                            bit_cnt  <= bit_cnt + 1'b1;
                            // Look at the next exponent bit before the shift
                            state    <= d_sh[1] ? core_multiply : core_square;
                        end
                    end
                end
                default: state <= core_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == core_idle && start) begin
            acc  <= key_bits'(1);
            d_sh <= d;
        end
        if (state == core_prep && mp_finished) begin
            pw <= mp_result;
        end
        // Ordinary times Montgomery gives ordinary
        if (state == core_multiply && mm_finished) begin
            acc <= mm_result;
        end
        if (state == core_square && mm_finished) begin
            pw   <= mm_result;
            d_sh <= d_sh >> 1;
        end
    end

endmodule

//--- rtl/rsa_wrapper.sv
module rsa_wrapper #(
    parameter int key_bits = rsa_pkg::default_key_bits
) (
    input  logic                          avm_clk,
    input  logic                          avm_rst,
    output logic [avm_pkg::addr_bits-1:0] avm_address,
    output logic                          avm_read,
    input  logic [31:0]                   avm_readdata,
    output logic                          avm_write,
    output logic [31:0]                   avm_writedata,
    input  logic                          avm_waitrequest
);
    import avm_pkg::*;

    localparam int n_bytes  = key_bits / 8;
    localparam int cnt_bits = $clog2(n_bytes + 1);

    bus_state_e          state;
    field_e              field;
    logic [cnt_bits-1:0] byte_cnt;
    logic [key_bits-1:0] n_r;
    logic [key_bits-1:0] d_r;
    logic [key_bits-1:0] c_r;
    logic [key_bits-1:0] tx_sh;
    logic [key_bits-1:0] core_result;
    logic                core_start;
    logic                core_finished;
    logic                last_rx;
    logic                last_tx;

    assign last_rx = (byte_cnt == cnt_bits'(n_bytes - 1));
    // Top byte is never sent
    assign last_tx = (byte_cnt == cnt_bits'(n_bytes - 2));

    assign avm_writedata = {24'd0, tx_sh[key_bits-1 -: 8]};

    rsa_core #(
        .key_bits (key_bits)
    ) u_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start),
        .a        (c_r),
        .d        (d_r),
        .n        (n_r),
        .result   (core_result),
        .finished (core_finished)
    );

    // ============================================================
    // Bus controller
    // ============================================================

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state       <= poll_rx;
            field       <= field_n;
            byte_cnt    <= '0;
            avm_address <= status_base;
            avm_read    <= 1'b1;
            avm_write   <= 1'b0;
            core_start  <= 1'b0;
        end else begin
            core_start <= 1'b0;
            case (state)
                poll_rx: begin
                    if (!avm_waitrequest && avm_readdata[rx_ok_bit]) begin
                        avm_address <= rx_base;
                        case (field)
                            field_n: state <= read_n;
                            field_d: state <= read_d;
                            default: state <= read_c;
                        endcase
                    end
                end
                read_n, read_d, read_c: begin
                    if (!avm_waitrequest) begin
                        if (last_rx) begin
                            byte_cnt <= '0;
                            case (field)
                                field_n: field <= field_d;
                                field_d: field <= field_c;
                                default: field <= field_n;
                            endcase
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                        if (last_rx && field == field_c) begin
                            avm_read   <= 1'b0;
                            core_start <= 1'b1;
                            state      <= compute;
                        end else begin
                            avm_address <= status_base;
                            state       <= poll_rx;
                        end
                    end
                end
                compute: begin
                    if (core_finished) begin
                        avm_read    <= 1'b1;
                        avm_address <= status_base;
                        state       <= poll_tx;
                    end
                end
                poll_tx: begin
                    if (!avm_waitrequest && avm_readdata[tx_ok_bit]) begin
                        avm_read    <= 1'b0;
                        avm_write   <= 1'b1;
                        avm_address <= tx_base;
                        state       <= send;
                    end
                end
                send: begin
                    if (!avm_waitrequest) begin
                        avm_write   <= 1'b0;
                        avm_read    <= 1'b1;
                        avm_address <= status_base;
                        if (last_tx) begin
                            byte_cnt <= '0;
                            state    <= poll_rx;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= poll_tx;
                        end
                    end
                end
                default: state <= poll_rx;
            endcase
        end
    end

    // Operand and result shift registers, MSB first
    always_ff @(posedge avm_clk) begin
        if (!avm_waitrequest) begin
            case (state)
                read_n: n_r <= {n_r[key_bits-9:0], avm_readdata[7:0]};
                read_d: d_r <= {d_r[key_bits-9:0], avm_readdata[7:0]};
                read_c: c_r <= {c_r[key_bits-9:0], avm_readdata[7:0]};
                send: tx_sh <= tx_sh << 8;
                default: begin
                end
            endcase
        end
        if (state == compute && core_finished) begin
            tx_sh <= {core_result[key_bits-9:0], 8'h00};
        end
    end

    // ============================================================
    // Bus checks
    // ============================================================

    a_one_strobe: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write));

    a_hold_stalled: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest
            |=> $stable(avm_address) && $stable(avm_read) && $stable(avm_write)
                && (!avm_write || $stable(avm_writedata)));

endmodule

//--- sim/avm_uart_model.sv
module avm_uart_model (
    input  logic                          avm_clk,
    input  logic                          avm_rst,
    input  logic [avm_pkg::addr_bits-1:0] avm_address,
    input  logic                          avm_read,
    output logic [31:0]                   avm_readdata,
    input  logic                          avm_write,
    input  logic [31:0]                   avm_writedata,
    output logic                          avm_waitrequest,
    input  logic [6:0]                    stall_pct,
    input  logic [6:0]                    tx_ok_pct,
    input  logic                          rx_push,
    input  logic [7:0]                    rx_data,
    output logic                          tx_seen,
    output logic [7:0]                    tx_byte,
    output logic [1:0]                    err
);
    import avm_pkg::*;

    integer     seed;
    logic [7:0] rx_q[$];
    int         rx_level;
    logic [7:0] rx_head;
    logic       tx_ok;
    // Set by a status read that reported tx_ok, used up by one write
    logic       tx_grant;

    initial begin
        seed = 46;
    end

    function automatic logic chance(input logic [6:0] pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    always_comb begin
        avm_readdata = '0;
        if (avm_address == status_base) begin
            avm_readdata[rx_ok_bit] = (rx_level != 0);
            avm_readdata[tx_ok_bit] = tx_ok;
        end else if (avm_address == rx_base) begin
            avm_readdata[7:0] = rx_head;
        end
    end

    always @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            avm_waitrequest <= 1'b0;
            tx_ok           <= 1'b0;
            tx_grant        <= 1'b0;
            tx_seen         <= 1'b0;
            tx_byte         <= 8'h00;
            err             <= 2'd0;
            rx_level        <= 0;
            rx_head         <= 8'h00;
            rx_q.delete();
        end else begin
            tx_seen <= 1'b0;
            if (avm_read && !avm_waitrequest) begin
                if (avm_address == rx_base) begin
                    if (rx_q.size() == 0) begin
                        err <= 2'd1;
                    end else begin
                        void'(rx_q.pop_front());
                    end
                end else if (avm_address == status_base) begin
                    tx_grant <= tx_ok;
                end
            end
            if (avm_write && !avm_waitrequest) begin
                if (avm_address != tx_base) begin
                    err <= 2'd3;
                end else if (!tx_grant) begin
                    err <= 2'd2;
                end
                tx_grant <= 1'b0;
                tx_seen  <= 1'b1;
                tx_byte  <= avm_writedata[7:0];
            end
            if (rx_push) begin
                rx_q.push_back(rx_data);
            end
            rx_level        <= rx_q.size();
            rx_head         <= (rx_q.size() != 0) ? rx_q[0] : 8'h00;
            avm_waitrequest <= chance(stall_pct);
            tx_ok           <= chance(tx_ok_pct);
        end
    end

endmodule

//--- sim/tb_rsa_wrapper.sv
module tb_rsa_wrapper;
    import avm_pkg::*;

    localparam int kb              = 64;
    localparam int nb              = kb / 8;
    localparam int clk_period      = 100;
    localparam int block_cycles    = 3 * kb * (kb + 4) + 64 * (4 * nb - 1);
    localparam int n_blocks        = 11;
    localparam int watchdog_cycles = block_cycles * n_blocks * 4;

    logic                 avm_clk;
    logic                 avm_rst;
    logic [addr_bits-1:0] avm_address;
    logic                 avm_read;
    logic [31:0]          avm_readdata;
    logic                 avm_write;
    logic [31:0]          avm_writedata;
    logic                 avm_waitrequest;
    logic [6:0]           stall_pct;
    logic [6:0]           tx_ok_pct;
    logic                 rx_push;
    logic [7:0]           rx_data;
    logic                 tx_seen;
    logic [7:0]           tx_byte;
    logic [1:0]           err;

    integer     seed;
    logic [7:0] tx_got[$];

    initial begin
        avm_clk = 1'b0;
    end

    always #(clk_period / 2) avm_clk = ~avm_clk;

    rsa_wrapper #(
        .key_bits (kb)
    ) u_dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    avm_uart_model u_model (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .stall_pct       (stall_pct),
        .tx_ok_pct       (tx_ok_pct),
        .rx_push         (rx_push),
        .rx_data         (rx_data),
        .tx_seen         (tx_seen),
        .tx_byte         (tx_byte),
        .err             (err)
    );

    // ============================================================
    // Reporting and compare tasks
    // ============================================================

    task automatic fail_run;
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_run;
        end
    endtask

    task automatic check_address(input string name, input logic [addr_bits-1:0] got,
                                 input logic [addr_bits-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_run;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            fail_run;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_run;
        end
    endtask

    always @(posedge avm_clk) begin
        if (err != 2'd0) begin
            case (err)
                2'd1: $display("Model error: receive register read while its queue was empty");
                2'd2: $display("Model error: transmit write without a status read showing tx_ok");
                default: $display("Model error: write to an address other than tx_base");
            endcase
            fail_run;
        end
    end

    always @(posedge avm_clk) begin
        if (tx_seen) begin
            tx_got.push_back(tx_byte);
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles", watchdog_cycles);
        fail_run;
    end

    // ============================================================
    // Reference model and stimulus helpers
    // ============================================================

    // Plain square-and-multiply with double-width products
    function automatic logic [kb-1:0] mod_exp(input logic [kb-1:0] base,
                                              input logic [kb-1:0] e,
                                              input logic [kb-1:0] m);
        logic [2*kb-1:0] r;
        logic [2*kb-1:0] b;
        r = 1;
        b = base % m;
        for (int i = 0; i < kb; i++) begin
            if (e[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[kb-1:0];
    endfunction

    task automatic push_byte(input logic [7:0] b, input int gap);
        @(posedge avm_clk);
        rx_push <= 1'b1;
        rx_data <= b;
        @(posedge avm_clk);
        rx_push <= 1'b0;
        repeat (gap) @(posedge avm_clk);
    endtask

    task automatic push_block(input logic [kb-1:0] n, input logic [kb-1:0] d,
                              input logic [kb-1:0] c, input int gap);
        for (int i = nb - 1; i >= 0; i--) begin
            push_byte(n[i*8 +: 8], gap);
        end
        for (int i = nb - 1; i >= 0; i--) begin
            push_byte(d[i*8 +: 8], gap);
        end
        for (int i = nb - 1; i >= 0; i--) begin
            push_byte(c[i*8 +: 8], gap);
        end
    endtask

    task automatic wait_tx(input int count, input int blocks);
        int cycles;
        cycles = 0;
        while (tx_got.size() < count) begin
            @(posedge avm_clk);
            cycles++;
            if (cycles > block_cycles * 4 * blocks) begin
                $display("Timeout waiting for transmit bytes: %0d of %0d after %0d cycles",
                         tx_got.size(), count, cycles);
                fail_run;
            end
        end
    endtask

    // Sent bytes in MSB-first order against the result without its top byte
    task automatic check_result(input int first, input logic [kb-1:0] expected);
        for (int j = 0; j < nb - 1; j++) begin
            check_byte($sformatf("tx byte %0d", first + j), tx_got[first + j],
                       expected[(nb-2-j)*8 +: 8]);
        end
    endtask

    task automatic settle_and_count(input int total);
        repeat (64) @(posedge avm_clk);
        check_count("transmit writes", tx_generated_count(), total);
        @(negedge avm_clk);
        check_level("avm_write", avm_write, 1'b0);
    endtask

    function automatic int tx_generated_count;
        return tx_got.size();
    endfunction

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic test_reset_level;
        @(negedge avm_clk);
        check_level("avm_read", avm_read, 1'b1);
        check_level("avm_write", avm_write, 1'b0);
        check_address("avm_address", avm_address, status_base);
    endtask

    task automatic test_known_block;
        tx_got.delete();
        // Textbook key with n = 61 * 53 and plaintext 65
        push_block(64'd3233, 64'd2753, 64'd2790, 0);
        wait_tx(nb - 1, 1);
        check_result(0, 64'd65);
        settle_and_count(nb - 1);
    endtask

    task automatic test_edge_operands;
        logic [kb-1:0] n;
        logic [kb-1:0] c;
        logic [kb-1:0] d;
        tx_got.delete();
        n = 64'hC000_0000_0000_0001;
        c = 64'hFFFF_FFFF_FFFF_FFF0;
        push_block(n, 64'd1, c, 0);
        wait_tx(nb - 1, 1);
        check_result(0, c % n);
        d = {$random(seed), $random(seed)};
        push_block(n, d, 64'd0, 0);
        wait_tx(2 * (nb - 1), 1);
        check_result(nb - 1, 64'd0);
        settle_and_count(2 * (nb - 1));
    endtask

    task automatic run_random_blocks(input int count, input int gap);
        logic [kb-1:0] rn[$];
        logic [kb-1:0] rd[$];
        logic [kb-1:0] rc[$];
        logic [kb-1:0] v;
        tx_got.delete();
        for (int i = 0; i < count; i++) begin
            v     = {$random(seed), $random(seed)};
            v[kb-1] = 1'b1;
            v[0]    = 1'b1;
            rn.push_back(v);
            rd.push_back({$random(seed), $random(seed)});
            v = {$random(seed), $random(seed)};
            rc.push_back(v % rn[i]);
        end
        for (int i = 0; i < count; i++) begin
            push_block(rn[i], rd[i], rc[i], gap);
        end
        wait_tx(count * (nb - 1), count);
        for (int i = 0; i < count; i++) begin
            check_result(i * (nb - 1), mod_exp(rc[i], rd[i], rn[i]));
        end
        settle_and_count(count * (nb - 1));
    endtask

    task automatic test_random_keys;
        run_random_blocks(5, 0);
    endtask

    task automatic test_back_pressure;
        @(posedge avm_clk);
        stall_pct <= 7'd80;
        tx_ok_pct <= 7'd20;
        run_random_blocks(3, 12);
        @(posedge avm_clk);
        stall_pct <= 7'd25;
        tx_ok_pct <= 7'd60;
    endtask

    initial begin
        seed      = 46;
        avm_rst   = 1'b1;
        rx_push   = 1'b0;
        rx_data   = 8'h00;
        stall_pct = 7'd25;
        tx_ok_pct = 7'd60;
        repeat (8) @(posedge avm_clk);
        avm_rst <= 1'b0;

        test_reset_level();
        test_known_block();
        test_edge_operands();
        test_random_keys();
        test_back_pressure();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- build.f
rtl/rsa_pkg.sv
rtl/avm_pkg.sv
rtl/rsa_modprod.sv
rtl/rsa_mont.sv
rtl/rsa_core.sv
rtl/rsa_wrapper.sv
sim/avm_uart_model.sv
sim/tb_rsa_wrapper.sv

//--- Bender.yml
package:
  name: rsa_wrapper

sources:
  - rtl/rsa_pkg.sv
  - rtl/avm_pkg.sv
  - rtl/rsa_modprod.sv
  - rtl/rsa_mont.sv
  - rtl/rsa_core.sv
  - rtl/rsa_wrapper.sv
  - target: test
    files:
      - sim/avm_uart_model.sv
      - sim/tb_rsa_wrapper.sv
